/* source/mem_stage_pkg.sv */
package mem_stage_pkg;

    // width of the instruction tag carried through the pipe
    localparam int ptcid_w = 7;

    // access size of a memory operand
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } op_size_e;

    // where an operand value is taken from
    typedef enum logic [1:0] {
        SRC_REG = 2'd0,
        SRC_SEG = 2'd1,
        SRC_MEM = 2'd2,
        SRC_IMM = 2'd3
    } op_src_e;

    // instruction bundle entering the memory stage
    typedef struct packed {
        logic [ptcid_w-1:0] tag;
        op_size_e           size;
        logic [31:0]        mem_addr;
        logic               is_rep;
        logic               dir_down;
        logic [31:0]        rep_count;
        logic [31:0]        reg_val;
        logic [15:0]        seg_val;
        logic [31:0]        imm;
        op_src_e            op1_src;
        op_src_e            op2_src;
    } mem_inst_t;

    // operand pair handed to the next stage
    typedef struct packed {
        logic [ptcid_w-1:0] tag;
        logic [31:0]        addr;
        logic               last;
        logic [31:0]        op1;
        logic [31:0]        op2;
    } op_result_t;

    // bytes touched by one access of the given size
    function automatic logic [2:0] size_bytes(input op_size_e size);
        case (size)
            SIZE_BYTE: return 3'd1;
            SIZE_WORD: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

endpackage

/* source/mem_req_pkg.sv */
package mem_req_pkg;

    // request queue geometry
    localparam int req_depth = 4;
    localparam int req_ptr_w = $clog2(req_depth);
    localparam int req_cnt_w = $clog2(req_depth + 1);

    // data store size, byte addresses wrap modulo store_bytes
    localparam int store_bytes  = 64;
    localparam int store_addr_w = $clog2(store_bytes);

    // one memory access, plus the operand sources the consumer needs
    typedef struct packed {
        logic [mem_stage_pkg::ptcid_w-1:0] tag;
        mem_stage_pkg::op_size_e           size;
        logic [31:0]                       addr;
        logic                              last;
        logic [31:0]                       reg_val;
        logic [15:0]                       seg_val;
        logic [31:0]                       imm;
        mem_stage_pkg::op_src_e            op1_src;
        mem_stage_pkg::op_src_e            op2_src;
    } mem_req_t;

endpackage

/* source/rep_addr_gen.sv */
module rep_addr_gen (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid_in,
    input  mem_stage_pkg::mem_inst_t inst,
    input  logic                     full,
    output logic                     stall,
    output logic                     push,
    output mem_req_pkg::mem_req_t    push_req
);

    import mem_stage_pkg::*;
    import mem_req_pkg::*;

    typedef enum logic {
        GEN_IDLE,
        GEN_ISSUE
    } gen_state_e;

    gen_state_e  state;
    mem_inst_t   inst_q;
    logic [31:0] cur_addr;
    logic [31:0] remain;
    logic [31:0] start_cnt;
    logic [31:0] step;
    logic [31:0] addr_step;
    logic        accept;
    logic        last;

    assign accept = valid_in && !stall;

    // a plain instruction behaves like a rep of one
    assign start_cnt = inst.is_rep ? inst.rep_count : 32'd1;

    assign last = (remain == 32'd1);

    // iteration state freezes while the queue is full
    assign push  = (state == GEN_ISSUE) && !full;
    assign stall = (state == GEN_ISSUE) || full;

    // stride is the access size, negated when walking down
    assign step      = {29'd0, size_bytes(inst_q.size)};
    assign addr_step = inst_q.dir_down ? (32'd0 - step) : step;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= GEN_IDLE;
            remain <= 32'd0;
        end else if (accept) begin
            // rep with zero count issues nothing
            state  <= (start_cnt != 32'd0) ? GEN_ISSUE : GEN_IDLE;
            remain <= start_cnt;
        end else if (push) begin
            remain <= remain - 32'd1;
            if (last) begin
                state <= GEN_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q   <= inst;
            cur_addr <= inst.mem_addr;
        end else if (push) begin
            cur_addr <= cur_addr + addr_step;
        end
    end

    always_comb begin
        push_req.tag     = inst_q.tag;
        push_req.size    = inst_q.size;
        push_req.addr    = cur_addr;
        push_req.last    = last;
        push_req.reg_val = inst_q.reg_val;
        push_req.seg_val = inst_q.seg_val;
        push_req.imm     = inst_q.imm;
        push_req.op1_src = inst_q.op1_src;
        push_req.op2_src = inst_q.op2_src;
    end

    // upstream must hold off while the stage is busy
    a_no_valid_in_stall: assert property (
        @(posedge clk) disable iff (reset) valid_in |-> !stall
    ) else $error("valid_in raised while stall is high");

endmodule

/* source/mem_req_fifo.sv */
module mem_req_fifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  mem_req_pkg::mem_req_t push_req,
    input  logic                  pop,
    output logic                  full,
    output logic                  empty,
    output mem_req_pkg::mem_req_t head_req
);

    import mem_stage_pkg::*;
    import mem_req_pkg::*;

    mem_req_t             entries [req_depth];
    logic [req_ptr_w-1:0] wr_ptr;
    logic [req_ptr_w-1:0] rd_ptr;
    logic [req_cnt_w-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    function automatic logic [req_ptr_w-1:0] next_ptr(input logic [req_ptr_w-1:0] ptr);
        if (ptr == req_ptr_w'(req_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == req_cnt_w'(req_depth));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_req = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    a_push_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    ) else $error("request pushed into a full queue");

    a_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("request popped from an empty queue");

endmodule

/* source/operand_fetch.sv */
module operand_fetch (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      empty,
    input  mem_req_pkg::mem_req_t     head_req,
    input  logic                      out_hold,
    input  logic                      wb_valid,
    input  logic [31:0]               wb_addr,
    input  mem_stage_pkg::op_size_e   wb_size,
    input  logic [31:0]               wb_data,
    output logic                      pop,
    output logic                      result_valid,
    output mem_stage_pkg::op_result_t result
);

    import mem_stage_pkg::*;
    import mem_req_pkg::*;

    logic [7:0]  store [store_bytes];
    logic [31:0] mem_val;

    // byte i of an access, wrapped into the store
    function automatic logic [store_addr_w-1:0] byte_idx(input logic [31:0] addr,
                                                         input int i);
        return addr[store_addr_w-1:0] + store_addr_w'(i);
    endfunction

    function automatic logic [31:0] sel_operand(input op_src_e     src,
                                                input mem_req_t    req,
                                                input logic [31:0] mval);
        case (src)
            SRC_REG: return req.reg_val;
            SRC_SEG: return {16'd0, req.seg_val};
            SRC_MEM: return mval;
            default: return req.imm;
        endcase
    endfunction

    // consume whenever a request waits and downstream is free
    assign pop = !empty && !out_hold;

    // write-back, little-endian, low size bytes of wb_data
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < store_bytes; i++) begin
                store[i] <= 8'd0;
            end
        end else if (wb_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (i < int'(size_bytes(wb_size))) begin
                    store[byte_idx(wb_addr, i)] <= wb_data[8*i +: 8];
                end
            end
        end
    end

    // little-endian read of the head request, zero-extended
    always_comb begin
        mem_val = 32'd0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(size_bytes(head_req.size))) begin
                mem_val[8*i +: 8] = store[byte_idx(head_req.addr, i)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result.tag  <= head_req.tag;
            result.addr <= head_req.addr;
            result.last <= head_req.last;
            result.op1  <= sel_operand(head_req.op1_src, head_req, mem_val);
            result.op2  <= sel_operand(head_req.op2_src, head_req, mem_val);
        end
    end

endmodule

/* source/mem_stage.sv */
module mem_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid_in,
    input  mem_stage_pkg::mem_inst_t  inst,
    output logic                      stall,
    input  logic                      wb_valid,
    input  logic [31:0]               wb_addr,
    input  mem_stage_pkg::op_size_e   wb_size,
    input  logic [31:0]               wb_data,
    input  logic                      out_hold,
    output logic                      result_valid,
    output mem_stage_pkg::op_result_t result
);

    import mem_stage_pkg::*;
    import mem_req_pkg::*;

    // producer to queue
    logic     push;
    logic     full;
    mem_req_t push_req;

    // queue to consumer
    logic     pop;
    logic     empty;
    mem_req_t head_req;

    rep_addr_gen u_rep_addr_gen (
        .clk      (clk),
        .reset    (reset),
        .valid_in (valid_in),
        .inst     (inst),
        .full     (full),
        .stall    (stall),
        .push     (push),
        .push_req (push_req)
    );

    mem_req_fifo u_mem_req_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .full     (full),
        .empty    (empty),
        .head_req (head_req)
    );

    operand_fetch u_operand_fetch (
        .clk          (clk),
        .reset        (reset),
        .empty        (empty),
        .head_req     (head_req),
        .out_hold     (out_hold),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_size      (wb_size),
        .wb_data      (wb_data),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* verif/mem_stage_checker.sv */
module mem_stage_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      result_valid,
    input  mem_stage_pkg::op_result_t result,
    output int                        mismatch_count,
    output int                        extra_count,
    output int                        pending
);

    import mem_stage_pkg::*;

    // expected results in issue order
    op_result_t exp_q [$];

    initial begin
        mismatch_count = 0;
        extra_count    = 0;
        pending        = 0;
    end

    task automatic add_expected(input op_result_t e);
        exp_q.push_back(e);
        pending = exp_q.size();
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (exp !== got) begin
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp, got);
            mismatch_count++;
        end
    endtask

    // result is registered, so mid-cycle it is settled
    always @(negedge clk) begin : check_result
        op_result_t e;
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result with tag %h at time %0t, nothing was expected",
                         result.tag, $time);
                extra_count++;
            end else begin
                e = exp_q.pop_front();
                pending = exp_q.size();
                compare_field("tag", 32'(e.tag), 32'(result.tag));
                compare_field("addr", e.addr, result.addr);
                compare_field("last", 32'(e.last), 32'(result.last));
                compare_field("op1", e.op1, result.op1);
                compare_field("op2", e.op2, result.op2);
            end
        end
    end

endmodule

/* verif/mem_stage_tb.sv */
module mem_stage_tb;

    import mem_stage_pkg::*;

    logic        clk;
    logic        reset;
    logic        valid_in;
    mem_inst_t   inst;
    logic        stall;
    logic        wb_valid;
    logic [31:0] wb_addr;
    op_size_e    wb_size;
    logic [31:0] wb_data;
    logic        out_hold;
    logic        result_valid;
    op_result_t  result;
    int          mismatch_count;
    int          extra_count;
    int          pending;
    int          tb_errors;
    logic        aborted;
    int          seed;

    mem_stage dut0 (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (valid_in),
        .inst         (inst),
        .stall        (stall),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_size      (wb_size),
        .wb_data      (wb_data),
        .out_hold     (out_hold),
        .result_valid (result_valid),
        .result       (result)
    );

    mem_stage_checker chk (
        .clk            (clk),
        .reset          (reset),
        .result_valid   (result_valid),
        .result         (result),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall && !aborted) begin
            next_cycle();
            cycles++;
            if (cycles >= 200) begin
                $display("timeout: stall stayed high for 200 cycles at time %0t", $time);
                tb_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0 && !aborted) begin
            next_cycle();
            cycles++;
            if (cycles >= 500) begin
                $display("timeout: %0d expected results never arrived", pending);
                tb_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    // earlier reads finish first so they cannot see the new data
    task automatic write_back(input logic [31:0] addr, input int size, input logic [31:0] data);
        wait_drain();
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_size  = op_size_e'(size);
        wb_data  = data;
        next_cycle();
        wb_valid = 1'b0;
    endtask

    task automatic issue_inst(input mem_inst_t i, input int hold);
        int gap;
        gap = $random(seed) & 1;
        repeat (gap) next_cycle();
        wait_stall_low();
        if (!aborted) begin
            valid_in = 1'b1;
            inst     = i;
            next_cycle();
            valid_in = 1'b0;
            // an instruction with at least one request keeps upstream held off
            if ((!i.is_rep || i.rep_count != 32'd0) && !stall) begin
                $display("FAILED at time %0t: stall low after accepting tag %h", $time, i.tag);
                tb_errors++;
            end
            // downstream busy right after acceptance
            if (hold > 0) begin
                out_hold = 1'b1;
                repeat (hold) next_cycle();
                out_hold = 1'b0;
            end
        end
    endtask

    task automatic report_bad_line(input string line);
        $display("malformed line in case file: %s", line);
        tb_errors++;
    endtask

    task automatic run_cases();
        int          fd;
        int          n;
        int          size;
        int          rep;
        int          dir;
        int          src1;
        int          src2;
        int          hold;
        int          last;
        string       line;
        string       rest;
        byte         kind;
        logic [31:0] tag;
        logic [31:0] addr;
        logic [31:0] cnt;
        logic [31:0] regv;
        logic [31:0] segv;
        logic [31:0] imm;
        logic [31:0] op1;
        logic [31:0] op2;
        mem_inst_t   i;
        op_result_t  e;
        fd = $fopen("verif/mem_stage_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open case file verif/mem_stage_cases.txt");
            tb_errors++;
            return;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (kind == "W") begin
                n = $sscanf(rest, "%h %d %h", addr, size, op1);
                if (n == 3) begin
                    write_back(addr, size, op1);
                end else begin
                    report_bad_line(line);
                end
            end else if (kind == "I") begin
                n = $sscanf(rest, "%h %d %h %d %d %h %h %h %h %d %d %d", tag, size, addr,
                            rep, dir, cnt, regv, segv, imm, src1, src2, hold);
                if (n == 12) begin
                    i           = '0;
                    i.tag       = tag[ptcid_w-1:0];
                    i.size      = op_size_e'(size);
                    i.mem_addr  = addr;
                    i.is_rep    = rep[0];
                    i.dir_down  = dir[0];
                    i.rep_count = cnt;
                    i.reg_val   = regv;
                    i.seg_val   = segv[15:0];
                    i.imm       = imm;
                    i.op1_src   = op_src_e'(src1);
                    i.op2_src   = op_src_e'(src2);
                    issue_inst(i, hold);
                end else begin
                    report_bad_line(line);
                end
            end else if (kind == "E") begin
                n = $sscanf(rest, "%h %h %d %h %h", tag, addr, last, op1, op2);
                if (n == 5) begin
                    e.tag  = tag[ptcid_w-1:0];
                    e.addr = addr;
                    e.last = last[0];
                    e.op1  = op1;
                    e.op2  = op2;
                    chk.add_expected(e);
                end else begin
                    report_bad_line(line);
                end
            end else if (kind != "#" && kind != "\n") begin
                report_bad_line(line);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        seed      = 32'he92bf4fc;
        tb_errors = 0;
        aborted   = 1'b0;
        reset     = 1'b1;
        valid_in  = 1'b0;
        inst      = '0;
        wb_valid  = 1'b0;
        wb_addr   = 32'd0;
        wb_size   = SIZE_BYTE;
        wb_data   = 32'd0;
        out_hold  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        run_cases();
        if (!aborted) begin
            wait_drain();
        end
        $display("mismatches %0d, unexpected results %0d, testbench errors %0d",
                 mismatch_count, extra_count, tb_errors);
        if (mismatch_count + extra_count + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verif/mem_stage_cases.txt */
# W addr size data | E tag addr last op1 op2 (size 0/1/2 byte/word/dword)
# I tag size addr rep dir count reg seg imm src1 src2 hold (src 0 reg 1 seg 2 mem 3 imm)
W 00000010 2 a1b2c3d4
I 01 0 00000010 0 0 00000000 11111111 0000 00000000 2 0 0
E 01 00000010 1 000000d4 11111111
I 02 1 00000010 0 0 00000000 00000000 0000 22222222 2 3 0
E 02 00000010 1 0000c3d4 22222222
I 03 2 00000010 0 0 00000000 00000000 beef 00000000 2 1 0
E 03 00000010 1 a1b2c3d4 0000beef
# operand sources in both positions
I 04 2 00000010 0 0 00000000 12345678 8001 0badf00d 0 1 0
E 04 00000010 1 12345678 00008001
I 05 2 00000010 0 0 00000000 12345678 8001 0badf00d 1 0 0
E 05 00000010 1 00008001 12345678
I 06 2 00000010 0 0 00000000 12345678 8001 0badf00d 3 2 0
E 06 00000010 1 0badf00d a1b2c3d4
I 07 0 00000013 0 0 00000000 12345678 8001 0badf00d 2 3 0
E 07 00000013 1 000000a1 0badf00d
# rep strings, up and down
W 00000020 2 44332211
W 00000024 2 88776655
I 08 1 00000020 1 0 00000003 00000000 0000 00000000 2 0 0
E 08 00000020 0 00002211 00000000
E 08 00000022 0 00004433 00000000
E 08 00000024 1 00006655 00000000
I 09 2 00000024 1 1 00000002 00000000 0000 5a5a5a5a 2 3 0
E 09 00000024 0 88776655 5a5a5a5a
E 09 00000020 1 44332211 5a5a5a5a
I 0a 0 00000026 1 1 00000003 00000abc 0000 00000000 2 0 0
E 0a 00000026 0 00000077 00000abc
E 0a 00000025 0 00000066 00000abc
E 0a 00000024 1 00000055 00000abc
# zero count gives nothing
I 0b 2 00000020 1 0 00000000 00000000 0000 00000000 2 0 0
I 0c 2 00000020 0 0 00000000 0000000c 0000 00000000 2 0 0
E 0c 00000020 1 44332211 0000000c
# long hold fills the queue
I 0d 0 00000020 1 0 00000007 00000000 0000 000000ff 2 3 24
E 0d 00000020 0 00000011 000000ff
E 0d 00000021 0 00000022 000000ff
E 0d 00000022 0 00000033 000000ff
E 0d 00000023 0 00000044 000000ff
E 0d 00000024 0 00000055 000000ff
E 0d 00000025 0 00000066 000000ff
E 0d 00000026 1 00000077 000000ff
I 0e 1 00000024 0 0 00000000 00000000 1234 00000000 2 1 0
E 0e 00000024 1 00006655 00001234
# write-back then read, with wrap
W 00000050 2 cafebabe
I 0f 2 00000010 0 0 00000000 00000000 0000 00000000 2 0 0
E 0f 00000010 1 cafebabe 00000000
W 0000003e 2 deadbeef
I 10 2 0000007e 0 0 00000000 00000000 0000 00000000 2 0 0
E 10 0000007e 1 deadbeef 00000000
I 11 1 00000100 0 0 00000000 00000000 0000 00000000 2 0 0
E 11 00000100 1 0000dead 00000000
W 00000010 0 00000077
I 12 2 00000010 0 0 00000000 00000000 0000 00000000 2 0 0
E 12 00000010 1 cafeba77 00000000

/* vlog.f */
source/mem_stage_pkg.sv
source/mem_req_pkg.sv
source/rep_addr_gen.sv
source/mem_req_fifo.sv
source/operand_fetch.sv
source/mem_stage.sv
verif/mem_stage_checker.sv
verif/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  # rtl
  - files:
      - source/mem_stage_pkg.sv
      - source/mem_req_pkg.sv
      - source/rep_addr_gen.sv
      - source/mem_req_fifo.sv
      - source/operand_fetch.sv
      - source/mem_stage.sv
  # verif
  - target: test
    files:
      - verif/mem_stage_checker.sv
      - verif/mem_stage_tb.sv
